// File: flist.f
hdl/mac_pkg.sv
hdl/array_sequencer.sv
hdl/operand_buffer.sv
hdl/input_skew.sv
hdl/pe_grid.sv
hdl/post_config_regs.sv
hdl/result_drain.sv
hdl/mac_array_top.sv
test/mac_array_chk.sv
test/tb_mac_array.sv

// File: run.sh
#!/bin/sh
# Build and run the MAC array testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_mac_array \
    -f flist.f

# Assertion errors are counted, the testbench gives the verdict
./obj_dir/Vtb_mac_array +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "Result: FAILED" sim.log || ! grep -q "Result: PASSED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

// File: test/tb_mac_array.sv
// MAC array testbench
`timescale 1ns/1ps

module tb_mac_array import mac_pkg::*; ();

    // ==================================================
    // Test table
    // ==================================================
    localparam int NUM_TESTS = 6;
    localparam int TIMEOUT   = NUM_TESTS * (8 * ARRAY_N + 40);

    // Mode bits per row are relu, bias_en, acc_mode and disturb while busy
    localparam logic [3:0] MODES [NUM_TESTS] = '{
        4'b0000,    // Plain product
        4'b0100,    // Column bias
        4'b1000,    // ReLU only
        4'b1110,    // Accumulate onto the ReLU run, with bias
        4'b0101,    // Writes and start while busy
        4'b0010     // Accumulate, no post-processing
    };

    typedef struct packed {
        op_row_t [ARRAY_N-1:0]  a;
        op_row_t [ARRAY_N-1:0]  b;
        acc_row_t               bias;
        act_func_e              act;
        logic                   bias_en;
        logic                   acc_mode;
        logic                   disturb;
        acc_row_t [ARRAY_N-1:0] exp_res;
    } test_vec_t;

    test_vec_t table_q [NUM_TESTS];
    // Raw sums the grid should hold ahead of bias and activation
    acc_t      grid_model [ARRAY_N][ARRAY_N];

    logic              clk;
    logic              rst_n;
    logic              tpu_start;
    logic              acc_mode;
    act_func_e         act_func;
    logic              bias_en;
    op_wr_t            op_wr;
    bias_wr_t          bias_wr;
    logic              rd_en;
    logic [ADDR_W-1:0] rd_addr;
    logic              tpu_busy;
    logic              tpu_done;
    acc_row_t          rd_data;
    logic              rd_valid;
    int                cycle_cnt = 0;
    int unsigned       chk_fails;

    mac_array_top i_dut (
        .clk(clk), .rst_n(rst_n), .tpu_start(tpu_start), .acc_mode(acc_mode),
        .tpu_busy(tpu_busy), .tpu_done(tpu_done), .act_func(act_func), .bias_en(bias_en),
        .op_wr(op_wr), .bias_wr(bias_wr), .rd_en(rd_en), .rd_addr(rd_addr),
        .rd_data(rd_data), .rd_valid(rd_valid)
    );

    // Failed assertions seen so far in the bound checker
    assign chk_fails = i_dut.i_chk.done_errs + i_dut.i_chk.busy_errs
                     + i_dut.i_chk.fall_errs + i_dut.i_chk.rd_errs;

    // ==================================================
    // Clock and run limit
    // ==================================================
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            fail_stop($sformatf("Timeout: run did not finish within %0d cycles", TIMEOUT));
        end
    end

    always @(negedge clk) begin
        if (chk_fails != 0) begin
            fail_stop($sformatf("Bound checker saw %0d failed assertions", chk_fails));
        end
    end

    task automatic fail_stop(string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    // ==================================================
    // Reference model
    // ==================================================
    function automatic data_t rand_operand();
        return data_t'(int'($urandom_range(15)) - 8);
    endfunction

    // Optional bias, then clamp negatives under ReLU
    function automatic acc_t post_process(acc_t raw, acc_t b, logic en, act_func_e act);
        acc_t v;
        v = en ? raw + b : raw;
        if ((act == ACT_RELU) && (v < 0)) begin
            v = '0;
        end
        return v;
    endfunction

    task automatic build_table();
        acc_t  raw;
        data_t av;
        data_t bv;
        for (int t = 0; t < NUM_TESTS; t++) begin
            for (int r = 0; r < ARRAY_N; r++) begin
                for (int c = 0; c < ARRAY_N; c++) begin
                    table_q[t].a[r][c] = rand_operand();
                    table_q[t].b[r][c] = rand_operand();
                end
                table_q[t].bias[r] = acc_t'(int'($urandom_range(200)) - 100);
            end
            table_q[t].act      = MODES[t][3] ? ACT_RELU : ACT_NONE;
            table_q[t].bias_en  = MODES[t][2];
            table_q[t].acc_mode = MODES[t][1];
            table_q[t].disturb  = MODES[t][0];
            // Cell (i,j) sums B[k][i] * A[k][j] over k
            for (int i = 0; i < ARRAY_N; i++) begin
                for (int j = 0; j < ARRAY_N; j++) begin
                    raw = table_q[t].acc_mode ? grid_model[i][j] : '0;
                    for (int k = 0; k < ARRAY_N; k++) begin
                        av  = table_q[t].a[k][j];
                        bv  = table_q[t].b[k][i];
                        raw = raw + acc_t'(av) * acc_t'(bv);
                    end
                    grid_model[i][j] = raw;
                    table_q[t].exp_res[i][j] = post_process(raw, table_q[t].bias[j],
                                                            table_q[t].bias_en, table_q[t].act);
                end
            end
        end
    endtask

    // ==================================================
    // Host side tasks
    // ==================================================
    // A row and its bias in one cycle, the B row in the next
    task automatic load_operands(int t);
        for (int r = 0; r < ARRAY_N; r++) begin
            @(negedge clk);
            op_wr   = '{we_a: 1'b1, we_b: 1'b0, addr: ADDR_W'(r), row: table_q[t].a[r]};
            bias_wr = '{en: 1'b1, addr: ADDR_W'(r), data: table_q[t].bias[r]};
            @(negedge clk);
            op_wr   = '{we_a: 1'b0, we_b: 1'b1, addr: ADDR_W'(r), row: table_q[t].b[r]};
            bias_wr = '0;
        end
        @(negedge clk);
        op_wr = '0;
    endtask

    task automatic start_run(int t);
        @(negedge clk);
        act_func  = table_q[t].act;
        bias_en   = table_q[t].bias_en;
        acc_mode  = table_q[t].acc_mode;
        tpu_start = 1'b1;
        @(negedge clk);
        tpu_start = 1'b0;
        if (table_q[t].disturb) begin
            // All of this lands while busy and has no effect
            for (int n = 0; n < 3; n++) begin
                assert (tpu_busy === 1'b1) else
                    fail_stop($sformatf("Error: tpu_busy = %h, expected %h", tpu_busy, 1'b1));
                op_wr     = '{we_a: 1'b1, we_b: 1'b1, addr: ADDR_W'(n), row: '1};
                tpu_start = 1'b1;
                act_func  = (table_q[t].act == ACT_RELU) ? ACT_NONE : ACT_RELU;
                bias_en   = ~table_q[t].bias_en;
                acc_mode  = ~table_q[t].acc_mode;
                @(negedge clk);
            end
            op_wr     = '0;
            tpu_start = 1'b0;
        end
        // Wait for the done pulse
        while (tpu_done !== 1'b1) begin
            @(negedge clk);
        end
        @(negedge clk);
        assert (tpu_busy === 1'b0) else
            fail_stop($sformatf("Error: tpu_busy = %h, expected %h", tpu_busy, 1'b0));
    endtask

    task automatic check_read(int r, acc_row_t exp_row);
        assert (rd_valid === 1'b1) else
            fail_stop($sformatf("Error: rd_valid = %h, expected %h", rd_valid, 1'b1));
        assert (rd_data === exp_row) else
            fail_stop($sformatf("Error: rd_data row %0d = %h, expected %h",
                                r, rd_data, exp_row));
    endtask

    task automatic read_row(int r, acc_row_t exp_row);
        @(negedge clk);
        rd_en   = 1'b1;
        rd_addr = ADDR_W'(r);
        @(negedge clk);
        rd_en = 1'b0;
        check_read(r, exp_row);
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        void'($urandom(97889));
        rst_n     = 1'b0;
        tpu_start = 1'b0;
        acc_mode  = 1'b0;
        act_func  = ACT_NONE;
        bias_en   = 1'b0;
        op_wr     = '0;
        bias_wr   = '0;
        rd_en     = 1'b0;
        rd_addr   = '0;
        build_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Check idle outputs and read back an unwritten row as zero
        assert ((tpu_busy === 1'b0) && (tpu_done === 1'b0) && (rd_valid === 1'b0)) else
            fail_stop($sformatf("Error: tpu_busy = %h, tpu_done = %h, rd_valid = %h after reset",
                                tpu_busy, tpu_done, rd_valid));
        read_row(ARRAY_N - 1, '0);

        for (int t = 0; t < NUM_TESTS; t++) begin
            load_operands(t);
            start_run(t);
            for (int r = 0; r < ARRAY_N; r++) begin
                read_row(r, table_q[t].exp_res[r]);
            end
        end

        if (chk_fails == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            fail_stop($sformatf("Bound checker saw %0d failed assertions", chk_fails));
        end
    end

endmodule

// File: test/mac_array_chk.sv
// Control and read handshake checks
`timescale 1ns/1ps

module mac_array_chk (
    input logic clk,
    input logic rst_n,
    input logic tpu_busy,
    input logic tpu_done,
    input logic rd_en,
    input logic rd_valid
);

    // Failure counts per property
    int unsigned done_errs = 0;
    int unsigned busy_errs = 0;
    int unsigned fall_errs = 0;
    int unsigned rd_errs   = 0;

    // ==================================================
    // Run control
    // ==================================================
    // Done is a single-cycle pulse
    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        tpu_done |=> !tpu_done)
    else begin
        done_errs++;
        $error("tpu_done stayed high for more than one cycle");
    end

    a_done_busy: assert property (@(posedge clk) disable iff (!rst_n)
        tpu_done |-> tpu_busy)
    else begin
        busy_errs++;
        $error("tpu_done seen while tpu_busy was low");
    end

    // Busy drops right after the done cycle
    a_busy_fall: assert property (@(posedge clk) disable iff (!rst_n)
        tpu_done |=> !tpu_busy)
    else begin
        fall_errs++;
        $error("tpu_busy still high the cycle after tpu_done");
    end

    // ==================================================
    // Read port
    // ==================================================
    a_rd_valid: assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid |-> $past(rd_en))
    else begin
        rd_errs++;
        $error("rd_valid without rd_en in the previous cycle");
    end

endmodule

bind mac_array_top mac_array_chk i_chk (
    .clk(clk), .rst_n(rst_n), .tpu_busy(tpu_busy), .tpu_done(tpu_done),
    .rd_en(rd_en), .rd_valid(rd_valid)
);

// File: hdl/mac_array_top.sv
// Systolic MAC array top
`timescale 1ns/1ps

module mac_array_top import mac_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    // Run control
    input  logic              tpu_start,
    input  logic              acc_mode,
    output logic              tpu_busy,
    output logic              tpu_done,
    // Post-processing setup
    input  act_func_e         act_func,
    input  logic              bias_en,
    // Host writes
    input  op_wr_t            op_wr,
    input  bias_wr_t          bias_wr,
    // Host result read
    input  logic              rd_en,
    input  logic [ADDR_W-1:0] rd_addr,
    output acc_row_t          rd_data,
    output logic              rd_valid
);

    seq_ctrl_t ctrl;
    op_row_t   row_a;
    op_row_t   row_b;
    op_row_t   skew_a;
    op_row_t   skew_b;
    acc_row_t  acc_mat [ARRAY_N];
    acc_row_t  bias_row;
    act_func_e act_q;
    logic      bias_en_q;

    // ==================================================
    // Control and operand feed
    // ==================================================
    array_sequencer u_seq (
        .clk(clk), .rst_n(rst_n), .start(tpu_start), .acc_mode(acc_mode),
        .ctrl(ctrl), .busy(tpu_busy), .done(tpu_done)
    );

    operand_buffer u_opbuf (
        .clk(clk), .rst_n(rst_n), .wr(op_wr), .busy(tpu_busy), .ctrl(ctrl),
        .row_a(row_a), .row_b(row_b)
    );

    // A feeds the columns from the top, B feeds the rows from the left
    input_skew u_skew_a (
        .clk(clk), .rst_n(rst_n), .ctrl(ctrl), .row_in(row_a), .row_out(skew_a)
    );

    input_skew u_skew_b (
        .clk(clk), .rst_n(rst_n), .ctrl(ctrl), .row_in(row_b), .row_out(skew_b)
    );

    // ==================================================
    // Grid and result path
    // ==================================================
    pe_grid u_grid (
        .clk(clk), .rst_n(rst_n), .ctrl(ctrl), .a_top(skew_a), .b_left(skew_b),
        .acc(acc_mat)
    );

    post_config_regs u_cfg (
        .clk(clk), .rst_n(rst_n), .bias_wr(bias_wr), .start(tpu_start),
        .busy(tpu_busy), .act_func_in(act_func), .bias_en_in(bias_en),
        .bias(bias_row), .act_func(act_q), .bias_en(bias_en_q)
    );

    result_drain u_drain (
        .clk(clk), .rst_n(rst_n), .ctrl(ctrl), .acc(acc_mat), .bias(bias_row),
        .act_func(act_q), .bias_en(bias_en_q), .rd_en(rd_en), .rd_addr(rd_addr),
        .rd_data(rd_data), .rd_valid(rd_valid)
    );

endmodule

// File: hdl/result_drain.sv
// Result drain and read port
`timescale 1ns/1ps

module result_drain import mac_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  seq_ctrl_t         ctrl,
    input  acc_row_t          acc [ARRAY_N],
    input  acc_row_t          bias,
    input  act_func_e         act_func,
    input  logic              bias_en,
    input  logic              rd_en,
    input  logic [ADDR_W-1:0] rd_addr,
    output acc_row_t          rd_data,
    output logic              rd_valid
);

    acc_row_t          proc_row;
    acc_row_t          proc_q;
    logic [ADDR_W-1:0] addr_q;
    logic              wr_pend;
    acc_row_t          res_mem [ARRAY_N];

    // ==================================================
    // Bias and activation
    // ==================================================
    always_comb begin
        acc_t v;
        for (int j = 0; j < ARRAY_N; j++) begin
            v = acc[ctrl.row][j];
            if (bias_en) begin
                v = v + bias[j];
            end
            // ReLU clamps on the sign bit
            if ((act_func == ACT_RELU) && v[ACC_W-1]) begin
                v = '0;
            end
            proc_row[j] = v;
        end
    end

    // Stage the processed row with its address
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_pend <= 1'b0;
        end else begin
            wr_pend <= ctrl.drain_en;
        end
    end

    always_ff @(posedge clk) begin
        proc_q <= proc_row;
        addr_q <= ctrl.row;
    end

    // ==================================================
    // Result buffer
    // ==================================================
    // Drain write owns the port, host read waits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < ARRAY_N; r++) begin
                res_mem[r] <= '0;
            end
        end else if (wr_pend) begin
            res_mem[addr_q] <= proc_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en && !wr_pend) begin
            rd_data <= res_mem[rd_addr];
        end
    end

    // One-cycle read latency, dropped on a collision
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en && !wr_pend;
        end
    end

endmodule

// File: hdl/post_config_regs.sv
// Bias and activation setup
`timescale 1ns/1ps

module post_config_regs import mac_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  bias_wr_t  bias_wr,
    input  logic      start,
    input  logic      busy,
    input  act_func_e act_func_in,
    input  logic      bias_en_in,
    output acc_row_t  bias,
    output act_func_e act_func,
    output logic      bias_en
);

    // Per-column bias, writable at any time
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bias <= '0;
        end else if (bias_wr.en) begin
            bias[bias_wr.addr] <= bias_wr.data;
        end
    end

    // Setup is frozen for the whole run
    // Only a start seen while idle is taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            act_func <= ACT_NONE;
            bias_en  <= 1'b0;
        end else if (start && !busy) begin
            act_func <= act_func_in;
            bias_en  <= bias_en_in;
        end
    end

endmodule

// File: hdl/pe_grid.sv
// Multiply-accumulate cell grid
`timescale 1ns/1ps

module pe_grid import mac_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  seq_ctrl_t ctrl,
    input  op_row_t   a_top,
    input  op_row_t   b_left,
    output acc_row_t  acc [ARRAY_N]
);

    // ==================================================
    // Operand busses between cells
    // ==================================================
    // a_bus[i][j] enters cell (i,j) from above, b_bus[i][j] from the left
    data_t a_bus    [ARRAY_N+1][ARRAY_N];
    data_t b_bus    [ARRAY_N][ARRAY_N+1];
    acc_t  acc_cell [ARRAY_N][ARRAY_N];

    for (genvar e = 0; e < ARRAY_N; e++) begin : g_edge
        assign a_bus[0][e] = a_top[e];
        assign b_bus[e][0] = b_left[e];
    end

    // ==================================================
    // Cells
    // ==================================================
    for (genvar i = 0; i < ARRAY_N; i++) begin : g_row
        for (genvar j = 0; j < ARRAY_N; j++) begin : g_col
            data_t a_q;
            data_t b_q;
            acc_t  acc_q;

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    a_q   <= '0;
                    b_q   <= '0;
                    acc_q <= '0;
                end else begin
                    if (ctrl.clear_acc) begin
                        acc_q <= '0;
                    end else if (ctrl.grid_en) begin
                        acc_q <= acc_q + acc_t'(a_bus[i][j]) * acc_t'(b_bus[i][j]);
                    end
                    // Pass A down and B right
                    if (ctrl.grid_en) begin
                        a_q <= a_bus[i][j];
                        b_q <= b_bus[i][j];
                    end
                end
            end

            assign a_bus[i+1][j] = a_q;
            assign b_bus[i][j+1] = b_q;
            assign acc_cell[i][j] = acc_q;
        end
    end

    // Row i of the output is row i of the grid
    always_comb begin
        for (int r = 0; r < ARRAY_N; r++) begin
            for (int c = 0; c < ARRAY_N; c++) begin
                acc[r][c] = acc_cell[r][c];
            end
        end
    end

endmodule

// File: hdl/input_skew.sv
// Operand row skew
`timescale 1ns/1ps

module input_skew import mac_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  seq_ctrl_t ctrl,
    input  op_row_t   row_in,
    output op_row_t   row_out
);

    data_t lane_in  [ARRAY_N];
    data_t lane_out [ARRAY_N];
    logic  shift_en;

    // Lanes move during load and flush only
    assign shift_en = ctrl.load_en | ctrl.flush;

    // Flush pushes zeros behind the last row
    always_comb begin
        for (int m = 0; m < ARRAY_N; m++) begin
            lane_in[m] = ctrl.load_en ? row_in[m] : '0;
        end
    end

    for (genvar m = 0; m < ARRAY_N; m++) begin : g_lane
        if (m == 0) begin : g_direct
            // Element 0 goes straight in
            assign lane_out[m] = lane_in[m];
        end else begin : g_chain
            data_t chain [m];

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int k = 0; k < m; k++) begin
                        chain[k] <= '0;
                    end
                end else if (shift_en) begin
                    chain[0] <= lane_in[m];
                    for (int k = 1; k < m; k++) begin
                        chain[k] <= chain[k-1];
                    end
                end
            end

            assign lane_out[m] = chain[m-1];
        end
    end

    always_comb begin
        for (int m = 0; m < ARRAY_N; m++) begin
            row_out[m] = lane_out[m];
        end
    end

endmodule

// File: hdl/operand_buffer.sv
// Operand matrix buffer
`timescale 1ns/1ps

module operand_buffer import mac_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  op_wr_t    wr,
    input  logic      busy,
    input  seq_ctrl_t ctrl,
    output op_row_t   row_a,
    output op_row_t   row_b
);

    // One row per address, A and B side by side
    op_row_t mem_a [ARRAY_N];
    op_row_t mem_b [ARRAY_N];

    // Host side, locked out during a run
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < ARRAY_N; r++) begin
                mem_a[r] <= '0;
                mem_b[r] <= '0;
            end
        end else if (!busy) begin
            if (wr.we_a) begin
                mem_a[wr.addr] <= wr.row;
            end
            if (wr.we_b) begin
                mem_b[wr.addr] <= wr.row;
            end
        end
    end

    // Sequencer side
    // Zeros outside LOAD keep the skew inputs quiet
    always_comb begin
        row_a = '0;
        row_b = '0;
        if (ctrl.load_en) begin
            row_a = mem_a[ctrl.row];
            row_b = mem_b[ctrl.row];
        end
    end

endmodule

// File: hdl/array_sequencer.sv
// Run phase sequencer
`timescale 1ns/1ps

module array_sequencer import mac_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  logic      acc_mode,
    output seq_ctrl_t ctrl,
    output logic      busy,
    output logic      done
);

    // Longest phase is the flush, 2N-1 cycles
    localparam int CNT_W = $clog2(2 * ARRAY_N);

    seq_state_e       state_q;
    logic [CNT_W-1:0] cnt_q;

    // ==================================================
    // Phase FSM
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    cnt_q <= '0;
                    // Accumulate mode keeps the old sums
                    if (start) begin
                        state_q <= acc_mode ? LOAD : CLEAR;
                    end
                end
                CLEAR: begin
                    state_q <= LOAD;
                    cnt_q   <= '0;
                end
                LOAD: begin
                    if (cnt_q == CNT_W'(ARRAY_N - 1)) begin
                        state_q <= FLUSH;
                        cnt_q   <= '0;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                FLUSH: begin
                    // Lets the last skewed operands cross the grid
                    if (cnt_q == CNT_W'(2 * ARRAY_N - 2)) begin
                        state_q <= DRAIN;
                        cnt_q   <= '0;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                DRAIN: begin
                    if (cnt_q == CNT_W'(ARRAY_N - 1)) begin
                        state_q <= DONE;
                        cnt_q   <= '0;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= IDLE;
                    cnt_q   <= '0;
                end
            endcase
        end
    end

    // ==================================================
    // Per-phase strobes
    // ==================================================
    always_comb begin
        ctrl           = '0;
        ctrl.clear_acc = (state_q == CLEAR);
        ctrl.load_en   = (state_q == LOAD);
        ctrl.flush     = (state_q == FLUSH);
        ctrl.grid_en   = (state_q == LOAD) || (state_q == FLUSH);
        ctrl.drain_en  = (state_q == DRAIN);
        // Row index only means something while loading or draining
        if ((state_q == LOAD) || (state_q == DRAIN)) begin
            ctrl.row = cnt_q[ADDR_W-1:0];
        end
    end

    assign busy = (state_q != IDLE);
    assign done = (state_q == DONE);

endmodule

// File: hdl/mac_pkg.sv
// MAC array shared types
package mac_pkg;

    // ==================================================
    // Sizes
    // ==================================================
    localparam int ARRAY_N = 4;     // Grid side and matrix dimension
    localparam int DATA_W  = 8;
    localparam int ACC_W   = 32;
    localparam int ADDR_W  = (ARRAY_N > 1) ? $clog2(ARRAY_N) : 1;

    // Scalars and rows
    typedef logic signed [DATA_W-1:0] data_t;
    typedef logic signed [ACC_W-1:0]  acc_t;
    typedef data_t [ARRAY_N-1:0]      op_row_t;
    typedef acc_t  [ARRAY_N-1:0]      acc_row_t;

    // ==================================================
    // Bundles
    // ==================================================
    // Host write of one operand row
    typedef struct packed {
        logic              we_a;
        logic              we_b;
        logic [ADDR_W-1:0] addr;
        op_row_t           row;
    } op_wr_t;

    // Host write of one column bias
    typedef struct packed {
        logic              en;
        logic [ADDR_W-1:0] addr;
        acc_t              data;
    } bias_wr_t;

    // Phase strobes from the sequencer
    typedef struct packed {
        logic              grid_en;
        logic              clear_acc;
        logic              load_en;
        logic              flush;
        logic              drain_en;
        logic [ADDR_W-1:0] row;      // Load row or drain row
    } seq_ctrl_t;

    typedef enum logic [2:0] {IDLE, CLEAR, LOAD, FLUSH, DRAIN, DONE} seq_state_e;

    typedef enum logic {ACT_NONE = 1'b0, ACT_RELU = 1'b1} act_func_e;

endpackage
